/* vlog.f */
design/srio_lane_pkg.sv
design/srio_ctrl_pkg.sv
design/pcs_reset_sync.sv
design/lane_rx_unpack.sv
design/lane_tx_pack.sv
design/lane_flow_ctrl.sv
design/srio_serdes_adapter.sv
testbench/serdes_adapter_assertions.sv
testbench/tb_srio_serdes_adapter.sv

/* Makefile */
# Verilator build and run for the SerDes adapter testbench

VERILATOR ?= verilator
TOP       ?= tb_srio_serdes_adapter
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

PASS_TEXT := *** TEST PASSED ***
SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Output goes to the console and is searched for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* testbench/tb_srio_serdes_adapter.sv */
`default_nettype none

module tb_srio_serdes_adapter;

    import srio_lane_pkg::*;
    import srio_ctrl_pkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 4;
    localparam int SYNC_CYCLES     = 3;     // pcs_rst release after async_rst_n
    localparam int TABLE_LEN       = 48;
    localparam int WATCHDOG_CYCLES = TABLE_LEN + RESET_CYCLES + SYNC_CYCLES + 20;

    typedef struct packed {
        rx_word_t [LANE_COUNT-1:0]         rx_word;
        logic [LANE_COUNT-1:0]             rx_vld;
        lane_tx_symbols_t [LANE_COUNT-1:0] tx_symbols;
        lane_status_t                      status;
        logic                              tx_inhibit;
        serdes_user_ctrl_t                 user_ctrl;
        logic                              core_gt_rstn;
    } stim_t;

    typedef struct packed {
        lane_symbols_t [LANE_COUNT-1:0] rx_symbols;
        logic [LANE_COUNT-1:0]          rx_symbols_vld;
        tx_word_t [LANE_COUNT-1:0]      tx_word;
        serdes_rst_t                    serdes_rst;
        logic [LANE_COUNT-1:0]          rx_fifo_rden;
        logic [LANE_COUNT-1:0]          tx_vld;
        logic [LANE_COUNT-1:0]          chbond_start;
    } expect_t;

    logic                              gt_pcs_clk;
    logic                              async_rst_n;
    serdes_user_ctrl_t                 user_ctrl;
    logic                              core_gt_rstn;
    logic                              tx_inhibit;
    lane_status_t                      status;
    rx_word_t [LANE_COUNT-1:0]         rx_word;
    logic [LANE_COUNT-1:0]             rx_vld;
    tx_word_t [LANE_COUNT-1:0]         tx_word;
    lane_symbols_t [LANE_COUNT-1:0]    rx_symbols;
    logic [LANE_COUNT-1:0]             rx_symbols_vld;
    lane_tx_symbols_t [LANE_COUNT-1:0] tx_symbols;
    serdes_rst_t                       serdes_rst;
    logic [LANE_COUNT-1:0]             rx_fifo_rden;
    logic [LANE_COUNT-1:0]             tx_vld;
    logic [LANE_COUNT-1:0]             chbond_start;

    stim_t   stim_table   [TABLE_LEN];
    expect_t expect_table [TABLE_LEN];
    int      seed;

    srio_serdes_adapter u_srio_serdes_adapter (
        .gt_pcs_clk       (gt_pcs_clk),
        .async_rst_n      (async_rst_n),
        .user_ctrl_i      (user_ctrl),
        .core_gt_rstn_i   (core_gt_rstn),
        .tx_inhibit_i     (tx_inhibit),
        .status_i         (status),
        .rx_word_i        (rx_word),
        .rx_vld_i         (rx_vld),
        .tx_word_o        (tx_word),
        .rx_symbols_o     (rx_symbols),
        .rx_symbols_vld_o (rx_symbols_vld),
        .tx_symbols_i     (tx_symbols),
        .serdes_rst_o     (serdes_rst),
        .rx_fifo_rden_o   (rx_fifo_rden),
        .tx_vld_o         (tx_vld),
        .chbond_start_o   (chbond_start)
    );

    initial begin
        gt_pcs_clk = 1'b0;
        forever #(CLK_PERIOD / 2) gt_pcs_clk = ~gt_pcs_clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the stimulus table finished");
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout");
    end

    // ----------------------------------------
    // Reference model and table
    // ----------------------------------------
    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // Each lane flag set with a 1 in 8 chance
    function automatic logic [LANE_COUNT-1:0] rare_bits();
        logic [LANE_COUNT-1:0] bits;
        logic [31:0]           r;
        for (int l = 0; l < LANE_COUNT; l++) begin
            r       = rand32();
            bits[l] = (r[2:0] == 3'd0);
        end
        return bits;
    endfunction

    // Slot 0 is the first code group and lands in the top byte
    function automatic lane_symbols_t unpack_ref(input rx_word_t w);
        lane_symbols_t sym;
        sym.dat        = {w[7:0], w[17:10], w[27:20], w[37:30]};
        sym.isk        = {w[8], w[18], w[28], w[38]};
        sym.disperr    = {w[9], w[19], w[29], w[39]};
        sym.notintable = {w[80], w[81], w[82], w[83]};
        return sym;
    endfunction

    function automatic tx_word_t pack_ref(input lane_tx_symbols_t s);
        return {40'h0, 1'b0, s.isk[0], s.dat[7:0],   1'b0, s.isk[1], s.dat[15:8],
                       1'b0, s.isk[2], s.dat[23:16], 1'b0, s.isk[3], s.dat[31:24]};
    endfunction

    function automatic void build_table();
        lane_symbols_t [LANE_COUNT-1:0] held;
        logic [95:0]                    r96;
        logic [31:0]                    r;
        logic [3:0]                     combo;
        stim_t                          s;
        expect_t                        e;
        held = '0;   // Symbols come out of reset cleared
        for (int i = 0; i < TABLE_LEN; i++) begin
            s = '0;
            e = '0;
            for (int l = 0; l < LANE_COUNT; l++) begin
                r96                 = {rand32(), rand32(), rand32()};
                s.rx_word[l]        = r96[RX_WORD_W-1:0];
                s.tx_symbols[l].dat = rand32();
                r                   = rand32();
                s.tx_symbols[l].isk = r[3:0];
            end
            r                       = rand32();
            s.rx_vld                = (i < 2) ? '1 : r[LANE_COUNT-1:0];
            s.status.align_link     = ~rare_bits();
            s.status.rx_fifo_aempty = rare_bits();
            s.status.tx_fifo_full   = rare_bits();
            r                       = rand32();
            s.tx_inhibit            = (r[2:0] == 3'd0);
            if (i < 6) begin
                s.status.align_link     = '1;   // Directed cases start fully open
                s.status.rx_fifo_aempty = '0;
                s.status.tx_fifo_full   = '0;
                s.tx_inhibit            = 1'b0;
            end
            case (i)
                1: s.status.tx_fifo_full[2]   = 1'b1;   // Single lane full
                2: s.status.rx_fifo_aempty[1] = 1'b1;
                3: s.tx_inhibit               = 1'b1;
                4: s.status.align_link[3]     = 1'b0;
                default: ;
            endcase
            combo                  = i[3:0];   // Walks all control combinations
            s.user_ctrl.rstn       = combo[3];
            s.user_ctrl.pcs_tx_rst = combo[2];
            s.user_ctrl.pcs_rx_rst = combo[1];
            s.core_gt_rstn         = combo[0];

            for (int l = 0; l < LANE_COUNT; l++) begin
                if (s.rx_vld[l]) begin
                    held[l] = unpack_ref(s.rx_word[l]);
                end
                e.tx_word[l] = pack_ref(s.tx_symbols[l]);
            end
            e.rx_symbols     = held;
            e.rx_symbols_vld = s.rx_vld;
            e.rx_fifo_rden   = (s.status.rx_fifo_aempty == '0) ? '1 : '0;
            e.tx_vld         = (s.status.tx_fifo_full == '0 && !s.tx_inhibit) ? '1 : '0;
            e.chbond_start   = (s.status.align_link == '1) ? '1 : '0;
            e.serdes_rst.lane_rstn  = (combo[3] && combo[0]) ? '1 : '0;
            e.serdes_rst.pcs_tx_rst = (combo[2] || !combo[0]) ? '1 : '0;
            e.serdes_rst.pcs_rx_rst = (combo[1] || !combo[0]) ? '1 : '0;
            stim_table[i]   = s;
            expect_table[i] = e;
        end
    endfunction

    // ----------------------------------------
    // Drive and compare
    // ----------------------------------------
    task automatic compare_value(input string what, input logic [127:0] actual,
                                 input logic [127:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    function automatic int assertion_failures();
        return u_srio_serdes_adapter.u_serdes_adapter_assertions.backpressure_fails +
               u_srio_serdes_adapter.u_serdes_adapter_assertions.reserved_fails +
               u_srio_serdes_adapter.u_serdes_adapter_assertions.idle_fails;
    endfunction

    task automatic halt_on_assertion();
        if (assertion_failures() != 0) begin
            $display("A concurrent assertion failed before time %0t", $time);
            $display("*** TEST FAILED ***");
            $fatal(1, "Assertion failure");
        end
    endtask

    task automatic drive_entry(input stim_t s);
        rx_word      = s.rx_word;
        rx_vld       = s.rx_vld;
        tx_symbols   = s.tx_symbols;
        status       = s.status;
        tx_inhibit   = s.tx_inhibit;
        user_ctrl    = s.user_ctrl;
        core_gt_rstn = s.core_gt_rstn;
    endtask

    task automatic expect_idle_outputs(input logic pcs_rst_exp);
        serdes_rst_t held_rst;
        held_rst.lane_rstn  = '0;   // All lanes held in reset
        held_rst.pcs_tx_rst = '1;
        held_rst.pcs_rx_rst = '1;
        compare_value("pcs_rst", 128'(u_srio_serdes_adapter.pcs_rst), 128'(pcs_rst_exp));
        compare_value("idle rx symbol valid", 128'(rx_symbols_vld), '0);
        compare_value("idle rx_fifo_rden", 128'(rx_fifo_rden), '0);
        compare_value("idle tx_vld", 128'(tx_vld), '0);
        compare_value("idle chbond_start", 128'(chbond_start), '0);
        compare_value("idle serdes resets", 128'(serdes_rst), 128'(held_rst));
    endtask

    task automatic score_entry(input int i);
        expect_t e;
        e = expect_table[i];
        for (int l = 0; l < LANE_COUNT; l++) begin
            compare_value($sformatf("entry %0d lane %0d rx symbols", i, l),
                          128'(rx_symbols[l]), 128'(e.rx_symbols[l]));
            compare_value($sformatf("entry %0d lane %0d tx word", i, l),
                          128'(tx_word[l]), 128'(e.tx_word[l]));
        end
        compare_value($sformatf("entry %0d rx symbol valid", i),
                      128'(rx_symbols_vld), 128'(e.rx_symbols_vld));
        compare_value($sformatf("entry %0d rx_fifo_rden", i),
                      128'(rx_fifo_rden), 128'(e.rx_fifo_rden));
        compare_value($sformatf("entry %0d tx_vld", i), 128'(tx_vld), 128'(e.tx_vld));
        compare_value($sformatf("entry %0d chbond_start", i),
                      128'(chbond_start), 128'(e.chbond_start));
        compare_value($sformatf("entry %0d serdes resets", i),
                      128'(serdes_rst), 128'(e.serdes_rst));
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        seed                   = 13263;
        async_rst_n            = 1'b0;
        user_ctrl.rstn         = 1'b1;   // Everything open, so holding is visible
        user_ctrl.pcs_tx_rst   = 1'b0;
        user_ctrl.pcs_rx_rst   = 1'b0;
        core_gt_rstn           = 1'b1;
        tx_inhibit             = 1'b0;
        status.align_link      = '1;
        status.rx_fifo_aempty  = '0;
        status.tx_fifo_full    = '0;
        rx_word                = '1;
        rx_vld                 = '1;
        tx_symbols             = '1;
        build_table();

        repeat (RESET_CYCLES) begin
            @(negedge gt_pcs_clk);
            expect_idle_outputs(1'b1);
        end
        async_rst_n = 1'b1;   // Released on a falling edge
        for (int c = 0; c < SYNC_CYCLES; c++) begin
            @(negedge gt_pcs_clk);
            expect_idle_outputs(c < SYNC_CYCLES - 1);
            halt_on_assertion();
        end

        // Each entry is checked one cycle after it is driven
        for (int i = 0; i < TABLE_LEN; i++) begin
            drive_entry(stim_table[i]);
            @(negedge gt_pcs_clk);
            score_entry(i);
            halt_on_assertion();
        end

        if (assertion_failures() != 0) begin
            $display("Concurrent assertions failed %0d times", assertion_failures());
            $display("*** TEST FAILED ***");
            $fatal(1, "Assertion failure");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* testbench/serdes_adapter_assertions.sv */
`default_nettype none

module serdes_adapter_assertions (
    input logic                                                    gt_pcs_clk,
    input logic                                                    async_rst_n,
    input logic                                                    pcs_rst_i,
    input srio_ctrl_pkg::lane_status_t                             status_i,
    input srio_lane_pkg::tx_word_t [srio_lane_pkg::LANE_COUNT-1:0] tx_word_i,
    input logic [srio_lane_pkg::LANE_COUNT-1:0]                    rx_symbols_vld_i,
    input logic [srio_lane_pkg::LANE_COUNT-1:0]                    rx_fifo_rden_i,
    input logic [srio_lane_pkg::LANE_COUNT-1:0]                    tx_vld_i,
    input logic [srio_lane_pkg::LANE_COUNT-1:0]                    chbond_start_i
);

    import srio_lane_pkg::*;

    int   backpressure_fails;   // Read by the testbench top
    int   reserved_fails;
    int   idle_fails;
    logic reserved_clear;

    // Disparity slot bits and the upper half of every lane word
    always_comb begin
        reserved_clear = 1'b1;
        for (int l = 0; l < LANE_COUNT; l++) begin
            if (tx_word_i[l][TX_WORD_W-1:SLOT_W*SYMBOLS_PER_LANE] != '0) begin
                reserved_clear = 1'b0;
            end
            for (int k = 0; k < SYMBOLS_PER_LANE; k++) begin
                if (tx_word_i[l][SLOT_W*k + 9]) begin
                    reserved_clear = 1'b0;
                end
            end
        end
    end

    // ----------------------------------------
    // Properties
    // ----------------------------------------
    backpressure_a: assert property (
        @(posedge gt_pcs_clk) disable iff (!async_rst_n)
        (|status_i.tx_fifo_full) |=> (tx_vld_i == '0)
    ) else begin
        $error("tx_vld still high one cycle after a full transmit FIFO");
        backpressure_fails++;
    end

    reserved_a: assert property (@(posedge gt_pcs_clk) reserved_clear)
    else begin
        $error("Reserved transmit word bits are not zero");
        reserved_fails++;
    end

    // Nothing moves while the PCS domain is in reset
    idle_a: assert property (
        @(posedge gt_pcs_clk) disable iff (!async_rst_n)
        pcs_rst_i |-> (rx_fifo_rden_i == '0 && tx_vld_i == '0 &&
                       chbond_start_i == '0 && rx_symbols_vld_i == '0)
    ) else begin
        $error("Lane outputs active while pcs_rst is high");
        idle_fails++;
    end

endmodule

bind srio_serdes_adapter serdes_adapter_assertions u_serdes_adapter_assertions (
    .gt_pcs_clk       (gt_pcs_clk),
    .async_rst_n      (async_rst_n),
    .pcs_rst_i        (pcs_rst),
    .status_i         (status_i),
    .tx_word_i        (tx_word_o),
    .rx_symbols_vld_i (rx_symbols_vld_o),
    .rx_fifo_rden_i   (rx_fifo_rden_o),
    .tx_vld_i         (tx_vld_o),
    .chbond_start_i   (chbond_start_o)
);

`default_nettype wire

/* design/srio_serdes_adapter.sv */
`default_nettype none

module srio_serdes_adapter (
    // ----------------------------------------
    // Clock, reset and control
    // ----------------------------------------
    input  logic                                                  gt_pcs_clk,
    input  logic                                                  async_rst_n,
    input  srio_ctrl_pkg::serdes_user_ctrl_t                      user_ctrl_i,
    input  logic                                                  core_gt_rstn_i,
    input  logic                                                  tx_inhibit_i,
    input  srio_ctrl_pkg::lane_status_t                           status_i,

    // Transceiver lane words
    input  srio_lane_pkg::rx_word_t [srio_lane_pkg::LANE_COUNT-1:0] rx_word_i,
    input  logic [srio_lane_pkg::LANE_COUNT-1:0]                  rx_vld_i,
    output srio_lane_pkg::tx_word_t [srio_lane_pkg::LANE_COUNT-1:0] tx_word_o,

    // Protocol core symbols
    output srio_lane_pkg::lane_symbols_t [srio_lane_pkg::LANE_COUNT-1:0] rx_symbols_o,
    output logic [srio_lane_pkg::LANE_COUNT-1:0]                  rx_symbols_vld_o,
    input  srio_lane_pkg::lane_tx_symbols_t [srio_lane_pkg::LANE_COUNT-1:0] tx_symbols_i,

    // ----------------------------------------
    // Reset and flow outputs
    // ----------------------------------------
    output srio_ctrl_pkg::serdes_rst_t                            serdes_rst_o,
    output logic [srio_lane_pkg::LANE_COUNT-1:0]                  rx_fifo_rden_o,
    output logic [srio_lane_pkg::LANE_COUNT-1:0]                  tx_vld_o,
    output logic [srio_lane_pkg::LANE_COUNT-1:0]                  chbond_start_o
);

    import srio_lane_pkg::*;

    logic pcs_rst;   // Synchronous to gt_pcs_clk, active high

    pcs_reset_sync u_pcs_reset_sync (
        .gt_pcs_clk     (gt_pcs_clk),
        .async_rst_n    (async_rst_n),
        .user_ctrl_i    (user_ctrl_i),
        .core_gt_rstn_i (core_gt_rstn_i),
        .pcs_rst_o      (pcs_rst),
        .serdes_rst_o   (serdes_rst_o)
    );

    lane_flow_ctrl u_lane_flow_ctrl (
        .gt_pcs_clk     (gt_pcs_clk),
        .async_rst_n    (async_rst_n),
        .pcs_rst_i      (pcs_rst),
        .status_i       (status_i),
        .tx_inhibit_i   (tx_inhibit_i),
        .rx_fifo_rden_o (rx_fifo_rden_o),
        .tx_vld_o       (tx_vld_o),
        .chbond_start_o (chbond_start_o)
    );

    // One receive and one transmit path per lane
    for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
        lane_rx_unpack u_lane_rx_unpack (
            .gt_pcs_clk    (gt_pcs_clk),
            .async_rst_n   (async_rst_n),
            .pcs_rst_i     (pcs_rst),
            .rx_word_i     (rx_word_i[i]),
            .rx_vld_i      (rx_vld_i[i]),
            .symbols_o     (rx_symbols_o[i]),
            .symbols_vld_o (rx_symbols_vld_o[i])
        );

        lane_tx_pack u_lane_tx_pack (
            .gt_pcs_clk  (gt_pcs_clk),
            .async_rst_n (async_rst_n),
            .pcs_rst_i   (pcs_rst),
            .symbols_i   (tx_symbols_i[i]),
            .tx_word_o   (tx_word_o[i])
        );
    end

endmodule

`default_nettype wire

/* design/lane_flow_ctrl.sv */
`default_nettype none

module lane_flow_ctrl (
    input  logic                                 gt_pcs_clk,
    input  logic                                 async_rst_n,
    input  logic                                 pcs_rst_i,
    input  srio_ctrl_pkg::lane_status_t          status_i,
    input  logic                                 tx_inhibit_i,
    output logic [srio_lane_pkg::LANE_COUNT-1:0] rx_fifo_rden_o,
    output logic [srio_lane_pkg::LANE_COUNT-1:0] tx_vld_o,
    output logic [srio_lane_pkg::LANE_COUNT-1:0] chbond_start_o
);

    import srio_lane_pkg::*;

    logic rx_all_ready;
    logic tx_all_open;
    logic all_aligned;

    // Lanes move in lockstep, so one lane holds back all of them
    assign rx_all_ready = ~|status_i.rx_fifo_aempty;
    assign tx_all_open  = ~|status_i.tx_fifo_full & ~tx_inhibit_i;
    assign all_aligned  = &status_i.align_link;

    always_ff @(posedge gt_pcs_clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            rx_fifo_rden_o <= '0;
            tx_vld_o       <= '0;
            chbond_start_o <= '0;
        end else if (pcs_rst_i) begin
            rx_fifo_rden_o <= '0;
            tx_vld_o       <= '0;
            chbond_start_o <= '0;
        end else begin
            rx_fifo_rden_o <= {LANE_COUNT{rx_all_ready}};
            tx_vld_o       <= {LANE_COUNT{tx_all_open}};   // Drops a cycle after any full
            chbond_start_o <= {LANE_COUNT{all_aligned}};
        end
    end

endmodule

`default_nettype wire

/* design/lane_tx_pack.sv */
`default_nettype none

module lane_tx_pack (
    input  logic                            gt_pcs_clk,
    input  logic                            async_rst_n,
    input  logic                            pcs_rst_i,
    input  srio_lane_pkg::lane_tx_symbols_t symbols_i,
    output srio_lane_pkg::tx_word_t         tx_word_o
);

    import srio_lane_pkg::*;

    tx_word_t tx_word_next;

    // Top data byte goes out first, in slot 0
    always_comb begin
        tx_word_next = '0;   // Disparity bits and upper half stay clear
        for (int k = 0; k < SYMBOLS_PER_LANE; k++) begin
            tx_word_next[SLOT_W*k +: 8] = symbols_i.dat[8*(SYMBOLS_PER_LANE-1-k) +: 8];
            tx_word_next[SLOT_W*k + 8]  = symbols_i.isk[SYMBOLS_PER_LANE-1-k];
        end
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge gt_pcs_clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            tx_word_o <= '0;
        end else if (pcs_rst_i) begin
            tx_word_o <= '0;
        end else begin
            tx_word_o <= tx_word_next;
        end
    end

endmodule

`default_nettype wire

/* design/lane_rx_unpack.sv */
`default_nettype none

module lane_rx_unpack (
    input  logic                         gt_pcs_clk,
    input  logic                         async_rst_n,
    input  logic                         pcs_rst_i,
    input  srio_lane_pkg::rx_word_t      rx_word_i,
    input  logic                         rx_vld_i,
    output srio_lane_pkg::lane_symbols_t symbols_o,
    output logic                         symbols_vld_o
);

    import srio_lane_pkg::*;

    lane_symbols_t symbols_next;

    // Slot k maps to symbol index SYMBOLS_PER_LANE-1-k
    always_comb begin
        symbols_next = '0;
        for (int k = 0; k < SYMBOLS_PER_LANE; k++) begin
            symbols_next.dat[8*(SYMBOLS_PER_LANE-1-k) +: 8] = rx_word_i[SLOT_W*k +: 8];
            symbols_next.isk[SYMBOLS_PER_LANE-1-k]        = rx_word_i[SLOT_W*k + 8];
            symbols_next.disperr[SYMBOLS_PER_LANE-1-k]    = rx_word_i[SLOT_W*k + 9];
            // Flags sit above the slots, slot 0 at the lowest bit
            symbols_next.notintable[SYMBOLS_PER_LANE-1-k] = rx_word_i[NOTINTABLE_BASE + k];
        end
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge gt_pcs_clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            symbols_o     <= '0;
            symbols_vld_o <= 1'b0;
        end else if (pcs_rst_i) begin
            symbols_o     <= '0;
            symbols_vld_o <= 1'b0;
        end else begin
            symbols_vld_o <= rx_vld_i;
            if (rx_vld_i) begin
                symbols_o <= symbols_next;   // Holds while the lane is idle
            end
        end
    end

endmodule

`default_nettype wire

/* design/pcs_reset_sync.sv */
`default_nettype none

module pcs_reset_sync (
    input  logic                             gt_pcs_clk,
    input  logic                             async_rst_n,
    input  srio_ctrl_pkg::serdes_user_ctrl_t user_ctrl_i,
    input  logic                             core_gt_rstn_i,
    output logic                             pcs_rst_o,
    output srio_ctrl_pkg::serdes_rst_t       serdes_rst_o
);

    import srio_lane_pkg::*;
    import srio_ctrl_pkg::*;

    logic [RST_SYNC_DEPTH-1:0] rst_chain;
    serdes_rst_t               serdes_rst_next;

    // ----------------------------------------
    // PCS domain reset chain
    // ----------------------------------------
    // Asserts at once, releases after RST_SYNC_DEPTH edges
    always_ff @(posedge gt_pcs_clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            rst_chain <= '1;
        end else begin
            rst_chain <= {rst_chain[RST_SYNC_DEPTH-2:0], 1'b0};
        end
    end

    assign pcs_rst_o = rst_chain[RST_SYNC_DEPTH-1];

    // ----------------------------------------
    // Transceiver reset combination
    // ----------------------------------------
    always_comb begin
        if (pcs_rst_o) begin
            // Hold every lane down until the PCS domain is out of reset
            serdes_rst_next.lane_rstn  = '0;
            serdes_rst_next.pcs_tx_rst = '1;
            serdes_rst_next.pcs_rx_rst = '1;
        end else begin
            serdes_rst_next.lane_rstn  = {LANE_COUNT{user_ctrl_i.rstn & core_gt_rstn_i}};
            serdes_rst_next.pcs_tx_rst = {LANE_COUNT{user_ctrl_i.pcs_tx_rst | ~core_gt_rstn_i}};
            serdes_rst_next.pcs_rx_rst = {LANE_COUNT{user_ctrl_i.pcs_rx_rst | ~core_gt_rstn_i}};
        end
    end

    always_ff @(posedge gt_pcs_clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            serdes_rst_o.lane_rstn  <= '0;
            serdes_rst_o.pcs_tx_rst <= '1;
            serdes_rst_o.pcs_rx_rst <= '1;
        end else begin
            serdes_rst_o <= serdes_rst_next;   // One cycle behind the controls
        end
    end

endmodule

`default_nettype wire

/* design/srio_ctrl_pkg.sv */
`default_nettype none

package srio_ctrl_pkg;

    // ----------------------------------------
    // Reset control
    // ----------------------------------------
    localparam int RST_SYNC_DEPTH = 3;  // Flops in the PCS reset chain

    // User side transceiver reset controls
    typedef struct packed {
        logic rstn;
        logic pcs_tx_rst;
        logic pcs_rx_rst;
    } serdes_user_ctrl_t;

    // Per-lane resets driven into the transceiver
    typedef struct packed {
        logic [srio_lane_pkg::LANE_COUNT-1:0] lane_rstn;   // Active low
        logic [srio_lane_pkg::LANE_COUNT-1:0] pcs_tx_rst;
        logic [srio_lane_pkg::LANE_COUNT-1:0] pcs_rx_rst;
    } serdes_rst_t;

    // ----------------------------------------
    // Lane status from the transceiver
    // ----------------------------------------
    typedef struct packed {
        logic [srio_lane_pkg::LANE_COUNT-1:0] align_link;      // Comma alignment done
        logic [srio_lane_pkg::LANE_COUNT-1:0] rx_fifo_aempty;
        logic [srio_lane_pkg::LANE_COUNT-1:0] tx_fifo_full;
    } lane_status_t;

endpackage

`default_nettype wire

/* design/srio_lane_pkg.sv */
`default_nettype none

package srio_lane_pkg;

    // ----------------------------------------
    // Lane geometry
    // ----------------------------------------
    localparam int LANE_COUNT       = 4;    // Transceiver lanes bonded into one port
    localparam int SYMBOLS_PER_LANE = 4;    // Code groups per PCS clock
    localparam int RX_WORD_W        = 88;
    localparam int TX_WORD_W        = 80;
    localparam int SLOT_W           = 10;   // 8 data bits, K flag, disparity error
    localparam int NOTINTABLE_BASE  = 80;   // Not-in-table flags, one per slot

    // ----------------------------------------
    // Raw transceiver words
    // ----------------------------------------
    // Slot k sits at bits SLOT_W*k and up, slot 0 received first
    typedef logic [RX_WORD_W-1:0] rx_word_t;
    typedef logic [TX_WORD_W-1:0] tx_word_t;

    // ----------------------------------------
    // Symbol views seen by the protocol core
    // ----------------------------------------
    // First code group of the cycle lands in the top byte
    typedef struct packed {
        logic [8*SYMBOLS_PER_LANE-1:0] dat;
        logic [SYMBOLS_PER_LANE-1:0]   isk;         // Control character flags
        logic [SYMBOLS_PER_LANE-1:0]   disperr;
        logic [SYMBOLS_PER_LANE-1:0]   notintable;  // 8b/10b decode misses
    } lane_symbols_t;

    // Transmit side carries no error flags
    typedef struct packed {
        logic [8*SYMBOLS_PER_LANE-1:0] dat;
        logic [SYMBOLS_PER_LANE-1:0]   isk;
    } lane_tx_symbols_t;

endpackage

`default_nettype wire
